//--- logic/ooo_types_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types for the commit back end: lane results, completion buffer
// writes and head view, predictor update and exception cause codes
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package ooo_types_pkg;

  typedef logic [31:0] word_t;     // data or address word
  typedef logic [4:0]  reg_idx_t;  // architectural dest reg
  typedef logic [3:0]  cb_tag_t;   // completion buffer index, max 16 entries
  typedef logic [1:0]  exc_cause_t;

  // exception causes carried through the completion buffer
  localparam exc_cause_t CAUSE_NONE      = 2'd0;
  localparam exc_cause_t CAUSE_MAL_INSN  = 2'd1;  // misaligned jump/branch target
  localparam exc_cause_t CAUSE_MAL_LOAD  = 2'd2;
  localparam exc_cause_t CAUSE_MAL_STORE = 2'd3;

  // arithmetic / branch / jump lane result
  typedef struct packed {
    logic     done;
    cb_tag_t  tag;
    word_t    pc;
    reg_idx_t vd;
    logic     wen;
    word_t    wdata;
    logic     branch_instr;
    logic     branch_taken;
    logic     prediction;    // predicted taken
    word_t    br_target;
    logic     jump_instr;
    word_t    jump_addr;
  } alu_result_t;

  // word load/store lane result
  typedef struct packed {
    logic     done;
    cb_tag_t  tag;
    word_t    pc;
    reg_idx_t vd;
    logic     wen;
    word_t    wdata;
    word_t    addr;
    logic     dren;
    logic     dwen;
  } ls_result_t;

  typedef struct packed {
    logic       valid;
    cb_tag_t    tag;
    word_t      wdata;       // result, pc on exception, target on mispredict
    logic       wen;
    logic       exception;
    exc_cause_t cause;
    logic       mispredict;
  } cb_write_t;

  typedef struct packed {
    logic       ready;
    reg_idx_t   vd;
    word_t      wdata;
    logic       wen;
    logic       exception;
    exc_cause_t cause;
    logic       mispredict;
  } cb_head_t;

  typedef struct packed {
    logic  valid;
    logic  taken;
    logic  prediction;
    word_t target;          // resolved address
  } pred_update_t;

  typedef enum logic {RUN, FLUSH} retire_state_e;

endpackage

`default_nettype wire

//--- logic/ooo_writeback_stage.sv
////////////////////////////////////////////////////////////////////////////
// writeback stage, turns lane results into registered completion buffer
// writes, flags misaligned targets/addresses and sends predictor update
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ooo_writeback_stage (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        flush,
  input  ooo_types_pkg::alu_result_t  alu_res,
  input  ooo_types_pkg::ls_result_t   ls_res,
  output ooo_types_pkg::cb_write_t    cb_wr_alu,
  output ooo_types_pkg::cb_write_t    cb_wr_ls,
  output ooo_types_pkg::pred_update_t pred_upd
);

  ooo_types_pkg::word_t        alu_resolved;  // branch outcome address
  ooo_types_pkg::word_t        alu_link;      // pc+4
  logic                        alu_mispredict;
  logic                        alu_mal_jump;
  logic                        alu_mal_branch;
  logic                        alu_exc;
  logic                        ls_mal;
  ooo_types_pkg::cb_write_t    alu_nxt, ls_nxt;
  ooo_types_pkg::cb_write_t    alu_q, ls_q;
  ooo_types_pkg::pred_update_t pred_nxt, pred_q;
  logic                        alu_vld_q, ls_vld_q, pred_vld_q;

  assign alu_link       = alu_res.pc + 32'd4;
  assign alu_resolved   = alu_res.branch_taken ? alu_res.br_target : alu_link;
  assign alu_mispredict = alu_res.branch_instr & (alu_res.prediction != alu_res.branch_taken);
  assign alu_mal_jump   = alu_res.jump_instr & (alu_res.jump_addr[1:0] != 2'b00);
  assign alu_mal_branch = alu_res.branch_instr & alu_res.branch_taken &
                          (alu_res.br_target[1:0] != 2'b00);  // only a taken branch faults
  assign alu_exc        = alu_mal_jump | alu_mal_branch;

  assign ls_mal = (ls_res.dren | ls_res.dwen) & (ls_res.addr[1:0] != 2'b00);

  // alu lane write, data picked by priority
  always_comb begin
    alu_nxt.valid      = alu_res.done;
    alu_nxt.tag        = alu_res.tag;
    alu_nxt.exception  = alu_exc;
    alu_nxt.cause      = alu_exc ? ooo_types_pkg::CAUSE_MAL_INSN : ooo_types_pkg::CAUSE_NONE;
    alu_nxt.mispredict = alu_mispredict & ~alu_exc;  // a fault takes over at retire
    alu_nxt.wen        = alu_res.wen & ~alu_res.branch_instr & ~alu_exc;
    if (alu_nxt.mispredict)
      alu_nxt.wdata = alu_resolved;  // becomes redirect pc
    else if (alu_exc)
      alu_nxt.wdata = alu_res.pc;    // becomes epc
    else if (alu_res.jump_instr)
      alu_nxt.wdata = alu_link;      // link value, wen kept
    else
      alu_nxt.wdata = alu_res.wdata;
  end

  // load/store lane write
  always_comb begin
    ls_nxt.valid      = ls_res.done;
    ls_nxt.tag        = ls_res.tag;
    ls_nxt.exception  = ls_mal;
    ls_nxt.mispredict = 1'b0;        // no control flow here
    ls_nxt.wen        = ls_res.wen & ~ls_res.dwen & ~ls_mal;  // stores never write rf
    ls_nxt.wdata      = ls_mal ? ls_res.pc : ls_res.wdata;
    if (!ls_mal)
      ls_nxt.cause = ooo_types_pkg::CAUSE_NONE;
    else if (ls_res.dren)
      ls_nxt.cause = ooo_types_pkg::CAUSE_MAL_LOAD;
    else
      ls_nxt.cause = ooo_types_pkg::CAUSE_MAL_STORE;
  end

  // predictor update, once per resolved branch
  assign pred_nxt = '{valid:      alu_res.done & alu_res.branch_instr,
                      taken:      alu_res.branch_taken,
                      prediction: alu_res.prediction,
                      target:     alu_resolved};

  // valid bits, dropped on flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      alu_vld_q  <= 1'b0;
      ls_vld_q   <= 1'b0;
      pred_vld_q <= 1'b0;
    end else if (flush) begin
      alu_vld_q  <= 1'b0;   // in-flight results die here
      ls_vld_q   <= 1'b0;
      pred_vld_q <= 1'b0;
    end else begin
      alu_vld_q  <= alu_nxt.valid;
      ls_vld_q   <= ls_nxt.valid;
      pred_vld_q <= pred_nxt.valid;
    end
  end

  // payload, loaded only with a live result
  always_ff @(posedge CLK) begin
    if (alu_res.done) alu_q <= alu_nxt;
    if (ls_res.done) ls_q <= ls_nxt;
    if (pred_nxt.valid) pred_q <= pred_nxt;
  end

  always_comb begin
    cb_wr_alu       = alu_q;
    cb_wr_alu.valid = alu_vld_q;
    cb_wr_ls        = ls_q;
    cb_wr_ls.valid  = ls_vld_q;
    pred_upd        = pred_q;
    pred_upd.valid  = pred_vld_q;
  end

endmodule

`default_nettype wire

//--- logic/completion_buffer.sv
////////////////////////////////////////////////////////////////////////////
// circular reorder buffer, allocated in program order at the tail, filled
// by two result ports in any order, drained in order from the head
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module completion_buffer #(
  parameter int CB_DEPTH = 8     // power of two, 16 max
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      alloc,
  input  ooo_types_pkg::reg_idx_t   alloc_vd,
  input  ooo_types_pkg::cb_write_t  cb_wr_alu,
  input  ooo_types_pkg::cb_write_t  cb_wr_ls,
  input  logic                      pop,
  input  logic                      flush,
  output ooo_types_pkg::cb_tag_t    alloc_tag,
  output logic                      cb_full,
  output ooo_types_pkg::cb_head_t   head
);

  localparam int PTR_W = $clog2(CB_DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(CB_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  ptr_t             head_q, tail_q;
  logic [PTR_W:0]   count_q;         // one extra bit to tell full from empty
  logic             alloc_ok;
  ptr_t             alu_idx, ls_idx;

  // per-entry state
  logic [CB_DEPTH-1:0]        ready_q;
  ooo_types_pkg::reg_idx_t    vd_q    [CB_DEPTH];
  ooo_types_pkg::word_t       wdata_q [CB_DEPTH];
  logic                       wen_q   [CB_DEPTH];
  logic                       exc_q   [CB_DEPTH];
  ooo_types_pkg::exc_cause_t  cause_q [CB_DEPTH];
  logic                       misp_q  [CB_DEPTH];

  assign cb_full   = (count_q == FULL_CNT);
  assign alloc_ok  = alloc & ~cb_full;       // alloc when full is dropped
  assign alloc_tag = ooo_types_pkg::cb_tag_t'(tail_q);
  assign alu_idx   = cb_wr_alu.tag[PTR_W-1:0];
  assign ls_idx    = cb_wr_ls.tag[PTR_W-1:0];

  // pointers and occupancy
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush) begin
      head_q  <= '0;    // next alloc gets tag 0
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc_ok) tail_q <= tail_q + 1'b1;  // wraps, depth is a power of two
      if (pop) head_q <= head_q + 1'b1;
      case ({alloc_ok, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ready bits
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ready_q <= '0;
    end else if (flush) begin
      ready_q <= '0;    // late writes are lost too
    end else begin
      if (alloc_ok) ready_q[tail_q] <= 1'b0;
      if (pop) ready_q[head_q] <= 1'b0;
      if (cb_wr_alu.valid) ready_q[alu_idx] <= 1'b1;
      if (cb_wr_ls.valid) ready_q[ls_idx] <= 1'b1;
    end
  end

  // entry payload
  always_ff @(posedge CLK) begin
    if (alloc_ok)
      vd_q[tail_q] <= alloc_vd;  // dest known at dispatch
    if (cb_wr_alu.valid) begin
      wdata_q[alu_idx] <= cb_wr_alu.wdata;
      wen_q[alu_idx]   <= cb_wr_alu.wen;
      exc_q[alu_idx]   <= cb_wr_alu.exception;
      cause_q[alu_idx] <= cb_wr_alu.cause;
      misp_q[alu_idx]  <= cb_wr_alu.mispredict;
    end
    if (cb_wr_ls.valid) begin
      wdata_q[ls_idx] <= cb_wr_ls.wdata;
      wen_q[ls_idx]   <= cb_wr_ls.wen;
      exc_q[ls_idx]   <= cb_wr_ls.exception;
      cause_q[ls_idx] <= cb_wr_ls.cause;
      misp_q[ls_idx]  <= cb_wr_ls.mispredict;
    end
  end

  // head view, combinational
  always_comb begin
    head.ready      = ready_q[head_q];
    head.vd         = vd_q[head_q];
    head.wdata      = wdata_q[head_q];
    head.wen        = wen_q[head_q];
    head.exception  = exc_q[head_q];
    head.cause      = cause_q[head_q];
    head.mispredict = misp_q[head_q];
  end

endmodule

`default_nettype wire

//--- logic/retire_unit.sv
////////////////////////////////////////////////////////////////////////////
// in-order retirement from the completion buffer head: rf write, exception
// report or fetch redirect, plus flush of everything younger
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module retire_unit (
  input  logic                       CLK,
  input  logic                       nRST,
  input  ooo_types_pkg::cb_head_t    head,
  input  logic                       retire_stall,
  output logic                       pop,
  output logic                       flush,
  output logic                       rf_wen,
  output ooo_types_pkg::reg_idx_t    rf_waddr,
  output ooo_types_pkg::word_t       rf_wdata,
  output logic                       exc_valid,
  output ooo_types_pkg::exc_cause_t  exc_cause,
  output ooo_types_pkg::word_t       epc,
  output logic                       redirect_valid,
  output ooo_types_pkg::word_t       redirect_pc
);

  ooo_types_pkg::retire_state_e state_q;
  logic take_exc;    // retiring a faulting entry
  logic take_misp;   // retiring a mispredicted branch
  logic take_norm;

  // head is ignored for the cycle the flush is out
  assign pop = (state_q == ooo_types_pkg::RUN) & head.ready & ~retire_stall;

  assign take_exc  = pop & head.exception;
  assign take_misp = pop & head.mispredict & ~head.exception;
  assign take_norm = pop & ~head.exception & ~head.mispredict;

  // state and strobes
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q        <= ooo_types_pkg::RUN;
      flush          <= 1'b0;
      rf_wen         <= 1'b0;
      exc_valid      <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      rf_wen         <= take_norm & head.wen;
      exc_valid      <= take_exc;
      redirect_valid <= take_misp;
      flush          <= take_exc | take_misp;  // lines up with exc/redirect
      case (state_q)
        ooo_types_pkg::RUN:
          if (take_exc | take_misp) state_q <= ooo_types_pkg::FLUSH;
        ooo_types_pkg::FLUSH:
          state_q <= ooo_types_pkg::RUN;       // buffer empty after this edge
        default:
          state_q <= ooo_types_pkg::RUN;
      endcase
    end
  end

  // payload regs
  always_ff @(posedge CLK) begin
    if (take_norm) begin
      rf_waddr <= head.vd;
      rf_wdata <= head.wdata;
    end
    if (take_exc) begin
      exc_cause <= head.cause;
      epc       <= head.wdata;   // writeback put the pc here
    end
    if (take_misp)
      redirect_pc <= head.wdata; // resolved branch address
  end

endmodule

`default_nettype wire

//--- logic/ooo_commit_top.sv
////////////////////////////////////////////////////////////////////////////
// commit back end top, writeback stage into completion buffer into retire
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ooo_commit_top #(
  parameter int CB_DEPTH = 8
) (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        alloc,
  input  ooo_types_pkg::reg_idx_t     alloc_vd,
  input  ooo_types_pkg::alu_result_t  alu_res,
  input  ooo_types_pkg::ls_result_t   ls_res,
  input  logic                        retire_stall,
  output ooo_types_pkg::cb_tag_t      alloc_tag,
  output logic                        cb_full,
  output ooo_types_pkg::pred_update_t pred_upd,
  output logic                        rf_wen,
  output ooo_types_pkg::reg_idx_t     rf_waddr,
  output ooo_types_pkg::word_t        rf_wdata,
  output logic                        exc_valid,
  output ooo_types_pkg::exc_cause_t   exc_cause,
  output ooo_types_pkg::word_t        epc,
  output logic                        redirect_valid,
  output ooo_types_pkg::word_t        redirect_pc
);

  ooo_types_pkg::cb_write_t cb_wr_alu, cb_wr_ls;
  ooo_types_pkg::cb_head_t  head;
  logic                     pop;
  logic                     flush;    // from retire to buffer and writeback

  ooo_writeback_stage u_wb (
    .CLK, .nRST, .flush,
    .alu_res, .ls_res,
    .cb_wr_alu, .cb_wr_ls, .pred_upd
  );

  completion_buffer #(.CB_DEPTH(CB_DEPTH)) u_cb (
    .CLK, .nRST,
    .alloc, .alloc_vd,
    .cb_wr_alu, .cb_wr_ls,
    .pop, .flush,
    .alloc_tag, .cb_full, .head
  );

  retire_unit u_retire (
    .CLK, .nRST, .head, .retire_stall,
    .pop, .flush,
    .rf_wen, .rf_waddr, .rf_wdata,
    .exc_valid, .exc_cause, .epc,
    .redirect_valid, .redirect_pc
  );

endmodule

`default_nettype wire

//--- tests/tb_ooo_commit.sv
////////////////////////////////////////////////////////////////////////////
// directed testbench for the commit back end that drives alloc and lane
// results and checks rf writes, exceptions, redirects and predictor updates
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_commit;

  localparam int CB_DEPTH   = 8;
  localparam int MAX_CYCLES = 2000;  // tests need a few hundred cycles

  logic                         CLK;
  logic                         nRST;
  logic                         alloc;
  ooo_types_pkg::reg_idx_t      alloc_vd;
  ooo_types_pkg::alu_result_t   alu_res;
  ooo_types_pkg::ls_result_t    ls_res;
  logic                         retire_stall;
  ooo_types_pkg::cb_tag_t       alloc_tag;
  logic                         cb_full;
  ooo_types_pkg::pred_update_t  pred_upd;
  logic                         rf_wen;
  ooo_types_pkg::reg_idx_t      rf_waddr;
  ooo_types_pkg::word_t         rf_wdata;
  logic                         exc_valid;
  ooo_types_pkg::exc_cause_t    exc_cause;
  ooo_types_pkg::word_t         epc;
  logic                         redirect_valid;
  ooo_types_pkg::word_t         redirect_pc;

  logic [36:0]                  rf_q[$];     // {waddr, wdata}
  logic [33:0]                  exc_q[$];    // {cause, epc}
  ooo_types_pkg::word_t         redir_q[$];
  ooo_types_pkg::pred_update_t  pred_q[$];
  ooo_types_pkg::cb_tag_t       exp_tail;    // model of the next tag
  int                           cycle_cnt = 0;

  ooo_commit_top #(.CB_DEPTH(CB_DEPTH)) DUT (
    .CLK, .nRST, .alloc, .alloc_vd, .alu_res, .ls_res, .retire_stall,
    .alloc_tag, .cb_full, .pred_upd,
    .rf_wen, .rf_waddr, .rf_wdata,
    .exc_valid, .exc_cause, .epc,
    .redirect_valid, .redirect_pc
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // cycle limit
  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // retire side events sampled mid cycle
  always @(negedge CLK) begin
    if (nRST) begin
      if (rf_wen) rf_q.push_back({rf_waddr, rf_wdata});
      if (exc_valid) exc_q.push_back({exc_cause, epc});
      if (redirect_valid) redir_q.push_back(redirect_pc);
      if (pred_upd.valid) pred_q.push_back(pred_upd);
    end
  end

  task automatic check(input logic [63:0] exp, input logic [63:0] act, input string what);
    if (exp !== act) begin
      $display("mismatch at %0d ns: %s, expected %h, got %h", $time, what, exp, act);
      $display("Test failed");
      $fatal(1, "value check");
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  // wait for the monitor to count enough retire events
  task automatic wait_events(input int n_rf, input int n_exc, input int n_redir);
    while (rf_q.size() < n_rf || exc_q.size() < n_exc || redir_q.size() < n_redir) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic do_alloc(input ooo_types_pkg::reg_idx_t vd, output ooo_types_pkg::cb_tag_t tag);
    check(64'(exp_tail), 64'(alloc_tag), "alloc tag");
    tag      = alloc_tag;
    alloc    = 1'b1;
    alloc_vd = vd;
    @(posedge CLK);
    #1;
    alloc    = 1'b0;
    exp_tail = ooo_types_pkg::cb_tag_t'((exp_tail + 1) % CB_DEPTH);
  endtask

  task automatic send_alu(input ooo_types_pkg::alu_result_t r);
    alu_res = r;
    @(posedge CLK);
    #1;
    alu_res = '0;
  endtask

  task automatic send_ls(input ooo_types_pkg::ls_result_t s);
    ls_res = s;
    @(posedge CLK);
    #1;
    ls_res = '0;
  endtask

  // plain alu result writing vd
  function automatic ooo_types_pkg::alu_result_t alu_op(input ooo_types_pkg::cb_tag_t tag,
      input ooo_types_pkg::word_t pc, input ooo_types_pkg::reg_idx_t vd,
      input ooo_types_pkg::word_t wdata);
    ooo_types_pkg::alu_result_t r;
    r       = '0;
    r.done  = 1'b1;
    r.tag   = tag;
    r.pc    = pc;
    r.vd    = vd;
    r.wen   = 1'b1;
    r.wdata = wdata;
    return r;
  endfunction

  // aligned load result
  function automatic ooo_types_pkg::ls_result_t load_op(input ooo_types_pkg::cb_tag_t tag,
      input ooo_types_pkg::word_t pc, input ooo_types_pkg::reg_idx_t vd,
      input ooo_types_pkg::word_t addr, input ooo_types_pkg::word_t wdata);
    ooo_types_pkg::ls_result_t s;
    s       = '0;
    s.done  = 1'b1;
    s.tag   = tag;
    s.pc    = pc;
    s.vd    = vd;
    s.wen   = 1'b1;
    s.wdata = wdata;
    s.addr  = addr;
    s.dren  = 1'b1;
    return s;
  endfunction

  // younger entries must be gone and tags restart at 0
  task automatic after_flush;
    idle(4);
    check(64'(0), 64'(rf_q.size()), "rf writes from flushed entries");
    check(64'(0), 64'(exc_q.size() + redir_q.size()), "extra exception or redirect");
    check(64'(0), 64'(alloc_tag), "alloc tag after flush");
    exp_tail = '0;
  endtask

  task automatic test_reset_state;
    check(64'(0), 64'(rf_wen), "rf_wen after reset");
    check(64'(0), 64'(exc_valid), "exc_valid after reset");
    check(64'(0), 64'(redirect_valid), "redirect_valid after reset");
    check(64'(0), 64'(pred_upd.valid), "pred_upd.valid after reset");
    check(64'(0), 64'(cb_full), "cb_full after reset");
    check(64'(0), 64'(alloc_tag), "alloc_tag after reset");
  endtask

  task automatic test_in_order;
    ooo_types_pkg::cb_tag_t      tags[4];
    ooo_types_pkg::word_t        data[4];
    ooo_types_pkg::cb_tag_t      tj, ts, tb, tn;
    ooo_types_pkg::word_t        dn;
    ooo_types_pkg::alu_result_t  r;
    ooo_types_pkg::ls_result_t   s;
    ooo_types_pkg::pred_update_t ep;
    int                          i;
    for (i = 0; i < 4; i++) begin
      do_alloc(5'(i + 1), tags[i]);
      data[i] = $urandom;
    end
    for (i = 3; i >= 0; i--) send_alu(alu_op(tags[i], 32'h1000 + 32'(4 * i), 5'(i + 1), data[i]));
    wait_events(4, 0, 0);
    for (i = 0; i < 4; i++)
      check(64'({5'(i + 1), data[i]}), 64'(rf_q.pop_front()), "rf write order");
    // four mixed ops completed in reverse order
    do_alloc(5'd5, tj);
    do_alloc(5'd6, ts);
    do_alloc(5'd7, tb);
    do_alloc(5'd8, tn);
    dn = $urandom;
    send_alu(alu_op(tn, 32'h2c, 5'd8, dn));
    r = alu_op(tb, 32'h28, 5'd7, $urandom);
    r.branch_instr = 1'b1;
    r.branch_taken = 1'b1;
    r.prediction   = 1'b1;
    r.br_target    = 32'h80;
    send_alu(r);
    s      = load_op(ts, 32'h24, 5'd6, 32'h3000, $urandom);
    s.dren = 1'b0;
    s.dwen = 1'b1;    // store drops its wen
    send_ls(s);
    r = alu_op(tj, 32'h20, 5'd5, $urandom);
    r.jump_instr = 1'b1;
    r.jump_addr  = 32'h100;
    send_alu(r);
    wait_events(2, 0, 0);
    check(64'({5'd5, 32'h24}), 64'(rf_q.pop_front()), "jump link value");
    check(64'({5'd8, dn}), 64'(rf_q.pop_front()), "op after branch");
    idle(4);
    check(64'(0), 64'(rf_q.size() + exc_q.size() + redir_q.size()), "extra retire events");
    ep = '{valid: 1'b1, taken: 1'b1, prediction: 1'b1, target: 32'h80};
    check(64'(1), 64'(pred_q.size()), "predictor update count");
    check(64'(ep), 64'(pred_q.pop_front()), "predictor update, correct branch");
  endtask

  task automatic misp_case(input logic br_taken);
    ooo_types_pkg::cb_tag_t      tbr, ty1, ty2;
    ooo_types_pkg::word_t        exp_pc;
    ooo_types_pkg::alu_result_t  r;
    ooo_types_pkg::pred_update_t ep;
    do_alloc(5'd9, tbr);
    do_alloc(5'd10, ty1);
    do_alloc(5'd11, ty2);
    send_alu(alu_op(ty2, 32'h308, 5'd11, $urandom));   // younger ones done first
    send_alu(alu_op(ty1, 32'h304, 5'd10, $urandom));
    r = alu_op(tbr, 32'h300, 5'd9, $urandom);
    r.branch_instr = 1'b1;
    r.branch_taken = br_taken;
    r.prediction   = ~br_taken;
    r.br_target    = 32'h440;
    send_alu(r);
    exp_pc = br_taken ? 32'h440 : 32'h304;
    wait_events(0, 0, 1);
    check(64'(exp_pc), 64'(redir_q.pop_front()), "redirect pc");
    ep = '{valid: 1'b1, taken: br_taken, prediction: ~br_taken, target: exp_pc};
    check(64'(1), 64'(pred_q.size()), "predictor update count");
    check(64'(ep), 64'(pred_q.pop_front()), "predictor update, mispredict");
    after_flush();
  endtask

  task automatic exc_case(input logic is_load);
    ooo_types_pkg::cb_tag_t     tf, ty;
    ooo_types_pkg::exc_cause_t  exp_cause;
    ooo_types_pkg::alu_result_t r;
    do_alloc(5'd12, tf);
    do_alloc(5'd13, ty);
    send_alu(alu_op(ty, 32'h504, 5'd13, $urandom));
    if (is_load) begin
      send_ls(load_op(tf, 32'h500, 5'd12, 32'h1002, $urandom));  // low bits set
      exp_cause = ooo_types_pkg::CAUSE_MAL_LOAD;
    end else begin
      r = alu_op(tf, 32'h500, 5'd12, $urandom);
      r.jump_instr = 1'b1;
      r.jump_addr  = 32'h602;
      send_alu(r);
      exp_cause = ooo_types_pkg::CAUSE_MAL_INSN;
    end
    wait_events(0, 1, 0);
    check(64'({exp_cause, 32'h500}), 64'(exc_q.pop_front()), "exception cause and epc");
    after_flush();
  endtask

  task automatic test_stall_full;
    ooo_types_pkg::cb_tag_t tags[8];
    ooo_types_pkg::word_t   data[8];
    int                     i;
    retire_stall = 1'b1;
    for (i = 0; i < 8; i++) begin
      do_alloc(5'(16 + i), tags[i]);
      data[i] = $urandom;
    end
    check(64'(1), 64'(cb_full), "cb_full after eight allocs");
    alloc    = 1'b1;  // one too many
    alloc_vd = 5'd31;
    @(posedge CLK);
    #1;
    alloc = 1'b0;
    check(64'(exp_tail), 64'(alloc_tag), "alloc while full ignored");
    check(64'(1), 64'(cb_full), "cb_full held");
    for (i = 0; i < 8; i++) begin
      if (i % 2 == 0)
        send_alu(alu_op(tags[i], 32'h700 + 32'(4 * i), 5'(16 + i), data[i]));
      else
        send_ls(load_op(tags[i], 32'h700 + 32'(4 * i), 5'(16 + i), 32'h2000, data[i]));
    end
    idle(4);
    check(64'(0), 64'(rf_q.size()), "rf write while stalled");
    retire_stall = 1'b0;
    wait_events(8, 0, 0);
    for (i = 0; i < 8; i++)
      check(64'({5'(16 + i), data[i]}), 64'(rf_q.pop_front()), "rf write after stall");
    check(64'(0), 64'(cb_full), "cb_full after drain");
  endtask

  initial begin
    void'($urandom(32'hca74));
    nRST         = 1'b0;
    alloc        = 1'b0;
    alloc_vd     = '0;
    alu_res      = '0;
    ls_res       = '0;
    retire_stall = 1'b0;
    exp_tail     = '0;
    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;
    test_reset_state();
    test_in_order();
    misp_case(1'b1);
    misp_case(1'b0);
    exc_case(1'b1);
    exc_case(1'b0);
    test_stall_full();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/ooo_types_pkg.sv
logic/ooo_writeback_stage.sv
logic/completion_buffer.sv
logic/retire_unit.sv
logic/ooo_commit_top.sv
tests/tb_ooo_commit.sv

//--- Makefile
# Verilator build and run of the commit back end testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f vlog.f --top-module tb_ooo_commit

run: compile
	./obj_dir/Vtb_ooo_commit

clean:
	rm -rf obj_dir
